// File: files.f
hw/aesTypesPkg.sv
hw/aesMathPkg.sv
hw/roundKeyStore.sv
hw/blockDeserializer.sv
hw/invCipherCore.sv
hw/blockSerializer.sv
hw/aesDecryptTop.sv
testbench/aesDecrypt_props.sv
testbench/tb_aesDecrypt.sv

// File: hw/aesDecryptTop.sv
`timescale 1ns/1ps

module aesDecryptTop import aesTypesPkg::*; (
    input  logic   clock,
    input  logic   arstN,
    input  logic   keyWrite,
    input  keyAddr keyAddress,
    input  aesByte keyByte,
    input  logic   inValid,
    input  aesByte inByte,
    output logic   outValid,
    output aesByte outByte,
    output logic   busy
);

    ////////////////////////////////////////
    // internal nets
    ////////////////////////////////////////

    aesBlock   cipherBlock;
    logic      blockReady;
    roundIndex roundSelect;
    aesBlock   roundKey;
    aesBlock   plainBlock;
    logic      blockDone;
    logic      draining;

    // key store beside the core
    roundKeyStore roundKeyStore_inst (
        .clock       (clock),
        .arstN       (arstN),
        .keyWrite    (keyWrite),
        .keyAddress  (keyAddress),
        .keyByte     (keyByte),
        .busy        (busy),
        .roundSelect (roundSelect),
        .roundKey    (roundKey)
    );

    // ciphertext bytes in
    blockDeserializer blockDeserializer_inst (
        .clock       (clock),
        .arstN       (arstN),
        .inValid     (inValid),
        .inByte      (inByte),
        .busy        (busy),
        .cipherBlock (cipherBlock),
        .blockReady  (blockReady)
    );

    // one round per clock
    invCipherCore invCipherCore_inst (
        .clock       (clock),
        .arstN       (arstN),
        .cipherBlock (cipherBlock),
        .blockReady  (blockReady),
        .roundKey    (roundKey),
        .draining    (draining),
        .roundSelect (roundSelect),
        .plainBlock  (plainBlock),
        .blockDone   (blockDone),
        .busy        (busy)
    );

    // plaintext bytes out
    blockSerializer blockSerializer_inst (
        .clock      (clock),
        .arstN      (arstN),
        .plainBlock (plainBlock),
        .blockDone  (blockDone),
        .outValid   (outValid),
        .outByte    (outByte),
        .draining   (draining)
    );

endmodule

// File: hw/aesMathPkg.sv
package aesMathPkg;

    import aesTypesPkg::*;

    ////////////////////////////////////////
    // inverse s-box, entry 0 in the top byte
    ////////////////////////////////////////

    localparam logic [2047:0] invSboxRom = {
        128'h52096ad53036a538bf40a39e81f3d7fb,
        128'h7ce339829b2fff87348e4344c4dee9cb,
        128'h547b9432a6c2233dee4c950b42fac34e,
        128'h082ea16628d924b2765ba2496d8bd125,
        128'h72f8f66486689816d4a45ccc5d65b692,
        128'h6c704850fdedb9da5e154657a78d9d84,
        128'h90d8ab008cbcd30af7e45805b8b34506,
        128'hd02c1e8fca3f0f02c1afbd0301138a6b,
        128'h3a9111414f67dcea97f2cfcef0b4e673,
        128'h96ac7422e7ad3585e2f937e81c75df6e,
        128'h47f11a711d29c5896fb7620eaa18be1b,
        128'hfc563e4bc6d279209adbc0fe78cd5af4,
        128'h1fdda8338807c731b11210592780ec5f,
        128'h60517fa919b54a0d2de57a9f93c99cef,
        128'ha0e03b4dae2af5b0c8ebbb3c83539961,
        128'h172b047eba77d626e169146355210c7d
    };

    function automatic aesByte invSbox(input aesByte x);
        return invSboxRom[8*(255 - int'(x)) +: 8];
    endfunction

    // multiply by x modulo the AES polynomial
    function automatic aesByte gfDouble(input aesByte b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    ////////////////////////////////////////
    // column and row transforms
    ////////////////////////////////////////

    // column byte 0 sits in bits 7:0
    function automatic logic [31:0] invMixColumn(input logic [31:0] col);
        aesByte a  [4];
        aesByte d2 [4];
        aesByte d4 [4];
        aesByte d8 [4];
        logic [31:0] result;
        for (int i = 0; i < 4; i++) begin
            a[i]  = col[8*i +: 8];
            d2[i] = gfDouble(a[i]);
            d4[i] = gfDouble(d2[i]);
            d8[i] = gfDouble(d4[i]);
        end
        // 0e 0b 0d 09 on a rotating window
        for (int i = 0; i < 4; i++) begin
            result[8*i +: 8] = (d8[i] ^ d4[i] ^ d2[i])
                             ^ (d8[(i+1)%4] ^ d2[(i+1)%4] ^ a[(i+1)%4])
                             ^ (d8[(i+2)%4] ^ d4[(i+2)%4] ^ a[(i+2)%4])
                             ^ (d8[(i+3)%4] ^ a[(i+3)%4]);
        end
        return result;
    endfunction

    // row r rotates right by r columns
    function automatic aesBlock invShiftBlock(input aesBlock blk);
        aesBlock result;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                result[8*(r + 4*c) +: 8] = blk[8*(r + 4*((c - r + 4) % 4)) +: 8];
            end
        end
        return result;
    endfunction

endpackage

// File: hw/aesTypesPkg.sv
package aesTypesPkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////

    // bytes per state block and per round key
    localparam int blockBytes = 16;
    // inverse rounds after the initial key add
    localparam int numRounds = 10;
    // eleven round keys of 16 bytes each
    localparam int keyStoreBytes = 176;

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////

    // one state or key byte
    typedef logic [7:0] aesByte;

    // full state or round key, byte 0 in bits 7:0
    typedef logic [8*blockBytes-1:0] aesBlock;

    // round number 0 to 10
    typedef logic [3:0] roundIndex;

    // byte address into the key store
    typedef logic [7:0] keyAddr;

endpackage

// File: hw/blockDeserializer.sv
`timescale 1ns/1ps

module blockDeserializer import aesTypesPkg::*; (
    input  logic    clock,
    input  logic    arstN,
    input  logic    inValid,
    input  aesByte  inByte,
    input  logic    busy,
    output aesBlock cipherBlock,
    output logic    blockReady
);

    // bytes collected so far in this block
    logic [3:0] byteCount;
    logic       accept;

    // strobes while busy are dropped
    assign accept = inValid && !busy;

    ////////////////////////////////////////
    // byte counter
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            byteCount  <= '0;
            blockReady <= 1'b0;
        end else begin
            blockReady <= 1'b0;
            if (accept) begin
                if (byteCount == 4'(blockBytes - 1)) begin
                    // last byte, pulse and restart
                    byteCount  <= '0;
                    blockReady <= 1'b1;
                end else begin
                    byteCount <= byteCount + 4'd1;
                end
            end
        end
    end

    // new byte enters at the top, byte 0 ends at the bottom
    always_ff @(posedge clock) begin
        if (accept) begin
            cipherBlock <= {inByte, cipherBlock[8*blockBytes-1:8]};
        end
    end

endmodule

// File: hw/blockSerializer.sv
`timescale 1ns/1ps

module blockSerializer import aesTypesPkg::*; (
    input  logic    clock,
    input  logic    arstN,
    input  aesBlock plainBlock,
    input  logic    blockDone,
    output logic    outValid,
    output aesByte  outByte,
    output logic    draining
);

    // byte being presented this cycle
    logic [3:0] byteCount;
    logic       active;
    aesBlock    shiftReg;

    ////////////////////////////////////////
    // output sequencing
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            active    <= 1'b0;
            byteCount <= '0;
        end else if (blockDone) begin
            active    <= 1'b1;
            byteCount <= '0;
        end else if (active) begin
            byteCount <= byteCount + 4'd1;
            // stop after byte 15
            if (byteCount == 4'(blockBytes - 1)) begin
                active <= 1'b0;
            end
        end
    end

    // byte 0 first, shift down one byte per cycle
    always_ff @(posedge clock) begin
        if (blockDone) begin
            shiftReg <= plainBlock;
        end else if (active) begin
            shiftReg <= shiftReg >> 8;
        end
    end

    assign outValid = active;
    assign outByte  = shiftReg[7:0];

    // low during the last byte so the core frees up in time
    assign draining = active && (byteCount != 4'(blockBytes - 1));

endmodule

// File: hw/invCipherCore.sv
`timescale 1ns/1ps

module invCipherCore import aesTypesPkg::*, aesMathPkg::*; (
    input  logic      clock,
    input  logic      arstN,
    input  aesBlock   cipherBlock,
    input  logic      blockReady,
    input  aesBlock   roundKey,
    input  logic      draining,
    output roundIndex roundSelect,
    output aesBlock   plainBlock,
    output logic      blockDone,
    output logic      busy
);

    typedef enum logic [1:0] {
        phaseIdle,
        phaseRounds,
        phaseHandoff,
        phaseDrain
    } corePhase;

    corePhase  phase;
    // counts 9 down to 0
    roundIndex roundCount;
    aesBlock   stateReg;

    // one inverse round, combinational
    aesBlock shifted;
    aesBlock subbed;
    aesBlock keyed;
    aesBlock roundOut;

    ////////////////////////////////////////
    // key selection
    ////////////////////////////////////////

    // round key 10 is presented while idle for the initial add
    assign roundSelect = (phase == phaseRounds) ? roundCount : roundIndex'(numRounds);

    ////////////////////////////////////////
    // round datapath
    ////////////////////////////////////////

    always_comb begin
        shifted = invShiftBlock(stateReg);
        for (int i = 0; i < blockBytes; i++) begin
            subbed[8*i +: 8] = invSbox(shifted[8*i +: 8]);
        end
        keyed = subbed ^ roundKey;
        // last round skips the column mix
        if (roundCount == '0) begin
            roundOut = keyed;
        end else begin
            for (int c = 0; c < 4; c++) begin
                roundOut[32*c +: 32] = invMixColumn(keyed[32*c +: 32]);
            end
        end
    end

    ////////////////////////////////////////
    // round FSM
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            phase      <= phaseIdle;
            roundCount <= '0;
            blockDone  <= 1'b0;
        end else begin
            blockDone <= 1'b0;
            case (phase)
                phaseIdle: begin
                    if (blockReady) begin
                        phase      <= phaseRounds;
                        roundCount <= roundIndex'(numRounds - 1);
                    end
                end
                phaseRounds: begin
                    if (roundCount == '0) begin
                        // plaintext lands in stateReg this edge
                        phase     <= phaseHandoff;
                        blockDone <= 1'b1;
                    end else begin
                        roundCount <= roundCount - 4'd1;
                    end
                end
                phaseHandoff: begin
                    // serializer captures on this edge
                    phase <= phaseDrain;
                end
                phaseDrain: begin
                    if (!draining) begin
                        phase <= phaseIdle;
                    end
                end
                default: begin
                    phase <= phaseIdle;
                end
            endcase
        end
    end

    // state register
    always_ff @(posedge clock) begin
        if (phase == phaseIdle && blockReady) begin
            stateReg <= cipherBlock ^ roundKey;
        end else if (phase == phaseRounds) begin
            stateReg <= roundOut;
        end
    end

    assign plainBlock = stateReg;

    // high from the blockReady pulse until the last byte leaves
    assign busy = blockReady || (phase != phaseIdle);

endmodule

// File: hw/roundKeyStore.sv
`timescale 1ns/1ps

module roundKeyStore import aesTypesPkg::*; (
    input  logic      clock,
    input  logic      arstN,
    input  logic      keyWrite,
    input  keyAddr    keyAddress,
    input  aesByte    keyByte,
    input  logic      busy,
    input  roundIndex roundSelect,
    output aesBlock   roundKey
);

    // expanded key bytes, round 0 at the bottom
    aesByte keyMem [keyStoreBytes];

    // registered write stage
    logic   wrPending;
    keyAddr wrAddr;
    aesByte wrData;

    ////////////////////////////////////////
    // write port
    ////////////////////////////////////////

    // accepted only in range and while idle
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            wrPending <= 1'b0;
        end else begin
            wrPending <= keyWrite && !busy && (int'(keyAddress) < keyStoreBytes);
        end
    end

    always_ff @(posedge clock) begin
        wrAddr <= keyAddress;
        wrData <= keyByte;
        if (wrPending) begin
            keyMem[wrAddr] <= wrData;
        end
    end

    ////////////////////////////////////////
    // round key read
    ////////////////////////////////////////

    // sixteen bytes from 16*roundSelect, zero past round 10
    always_comb begin
        roundKey = '0;
        if (int'(roundSelect) <= numRounds) begin
            for (int i = 0; i < blockBytes; i++) begin
                roundKey[8*i +: 8] = keyMem[int'(roundSelect) * blockBytes + i];
            end
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_aesDecrypt -o tb_aesDecrypt
./obj_dir/tb_aesDecrypt | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: testbench/aesDecrypt_props.sv
`timescale 1ns/1ps

module aesDecrypt_props (
    input logic clock,
    input logic arstN,
    input logic outValid,
    input logic busy,
    input logic blockDone
);

    // bytes already out in the current burst
    logic [4:0] outCount;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            outCount <= '0;
        end else if (outValid) begin
            outCount <= outCount + 5'd1;
        end else begin
            outCount <= '0;
        end
    end

    outValidNeedsBusy: assert property (
        @(posedge clock) disable iff (!arstN) outValid |-> busy
    ) else $error("outValid high while busy low");

    doneStartsOutput: assert property (
        @(posedge clock) disable iff (!arstN) blockDone |=> outValid
    ) else $error("no outValid the cycle after blockDone");

    // bytes 1 to 15 follow with busy still high
    busyThroughOutput: assert property (
        @(posedge clock) disable iff (!arstN) (outValid && outCount < 5'd15) |=> (outValid && busy)
    ) else $error("output burst cut short or busy dropped");

endmodule

bind aesDecryptTop aesDecrypt_props aesDecrypt_props_inst (
    .clock     (clock),
    .arstN     (arstN),
    .outValid  (outValid),
    .busy      (busy),
    .blockDone (blockDone)
);

// File: testbench/tb_aesDecrypt.sv
`timescale 1ns/1ps

module tb_aesDecrypt import aesTypesPkg::*; ();

    localparam int resetCycles  = 16;
    localparam int latency      = 13;
    localparam int numBlocks    = 27;
    localparam int marginCycles = 40;
    // bytes in, latency, bytes out and a full key load per block
    localparam longint watchdogNs = longint'(numBlocks)
        * (blockBytes + latency + blockBytes + keyStoreBytes + marginCycles) * 40;

    logic   clock = 1'b0;
    logic   arstN;
    logic   keyWrite;
    keyAddr keyAddress;
    aesByte keyByte;
    logic   inValid;
    aesByte inByte;
    logic   outValid;
    aesByte outByte;
    logic   busy;

    // reference tables and expanded key
    aesByte sbox [256];
    aesByte isbox [256];
    aesByte rkBytes [keyStoreBytes];

    logic [31:0] lcgState;
    int errorCount  = 0;
    int testErrors  = 0;
    int testsPassed = 0;
    int testsFailed = 0;

    aesDecryptTop aesDecryptTop_inst (
        .clock(clock), .arstN(arstN), .keyWrite(keyWrite), .keyAddress(keyAddress),
        .keyByte(keyByte), .inValid(inValid), .inByte(inByte), .outValid(outValid),
        .outByte(outByte), .busy(busy)
    );

    always #20 clock = ~clock;

    initial begin
        #(watchdogNs);
        $display("watchdog fired after %0d ns, the run timed out", watchdogNs);
        $display("TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic aesBlock randomBlock();
        aesBlock blk;
        logic [31:0] r;
        for (int i = 0; i < blockBytes; i++) begin
            r = nextRand();
            blk[8*i +: 8] = r[31:24];
        end
        return blk;
    endfunction

    // shift-and-add product in GF(2^8)
    function automatic aesByte gfMul(input aesByte a, input aesByte b);
        aesByte p;
        aesByte x;
        aesByte y;
        p = 8'h00;
        x = a;
        y = b;
        for (int i = 0; i < 8; i++) begin
            if (y[0]) p ^= x;
            x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
            y = y >> 1;
        end
        return p;
    endfunction

    // a^254 is the inverse, 0 maps to 0
    function automatic aesByte gfInverse(input aesByte a);
        aesByte p;
        p = 8'h01;
        repeat (254) p = gfMul(p, a);
        return p;
    endfunction

    task automatic buildSboxes();
        aesByte b;
        aesByte s;
        for (int x = 0; x < 256; x++) begin
            b = gfInverse(aesByte'(x));
            // affine map
            s = b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]}
                  ^ {b[3:0], b[7:4]} ^ 8'h63;
            sbox[x]  = s;
            isbox[s] = aesByte'(x);
        end
    endtask

    task automatic expandKey(input aesBlock key);
        aesByte t [4];
        aesByte rcon;
        aesByte tmp;
        rcon = 8'h01;
        for (int i = 0; i < blockBytes; i++) rkBytes[i] = key[8*i +: 8];
        for (int w = 4; w < 44; w++) begin
            for (int j = 0; j < 4; j++) t[j] = rkBytes[4*(w-1) + j];
            if (w % 4 == 0) begin
                // rotate, substitute, add round constant
                tmp  = t[0];
                t[0] = sbox[t[1]] ^ rcon;
                t[1] = sbox[t[2]];
                t[2] = sbox[t[3]];
                t[3] = sbox[tmp];
                rcon = gfMul(rcon, 8'h02);
            end
            for (int j = 0; j < 4; j++) rkBytes[4*w + j] = rkBytes[4*(w-4) + j] ^ t[j];
        end
    endtask

    function automatic aesBlock modelDecrypt(input aesBlock ct);
        aesByte s [16];
        aesByte t [16];
        aesByte a [4];
        aesBlock pt;
        for (int i = 0; i < 16; i++) s[i] = ct[8*i +: 8] ^ rkBytes[16*numRounds + i];
        for (int rnd = numRounds - 1; rnd >= 0; rnd--) begin
            // row r moves right by r columns
            for (int r = 0; r < 4; r++)
                for (int c = 0; c < 4; c++) t[r + 4*((c + r) % 4)] = s[r + 4*c];
            for (int i = 0; i < 16; i++) s[i] = isbox[t[i]] ^ rkBytes[16*rnd + i];
            if (rnd > 0) begin
                for (int c = 0; c < 4; c++) begin
                    for (int j = 0; j < 4; j++) a[j] = s[4*c + j];
                    s[4*c]   = gfMul(a[0], 8'h0e) ^ gfMul(a[1], 8'h0b)
                             ^ gfMul(a[2], 8'h0d) ^ gfMul(a[3], 8'h09);
                    s[4*c+1] = gfMul(a[0], 8'h09) ^ gfMul(a[1], 8'h0e)
                             ^ gfMul(a[2], 8'h0b) ^ gfMul(a[3], 8'h0d);
                    s[4*c+2] = gfMul(a[0], 8'h0d) ^ gfMul(a[1], 8'h09)
                             ^ gfMul(a[2], 8'h0e) ^ gfMul(a[3], 8'h0b);
                    s[4*c+3] = gfMul(a[0], 8'h0b) ^ gfMul(a[1], 8'h0d)
                             ^ gfMul(a[2], 8'h09) ^ gfMul(a[3], 8'h0e);
                end
            end
        end
        for (int i = 0; i < 16; i++) pt[8*i +: 8] = s[i];
        return pt;
    endfunction

    // written hex puts byte 0 first
    function automatic aesBlock fromHex(input logic [127:0] h);
        aesBlock blk;
        for (int i = 0; i < 16; i++) blk[8*i +: 8] = h[8*(15 - i) +: 8];
        return blk;
    endfunction

    ////////////////////////////////////////
    // checks and drivers
    ////////////////////////////////////////

    task automatic checkByte(input string name, input aesByte expected, input aesByte actual);
        if (expected !== actual) begin
            errorCount++;
            testErrors++;
            $display("Error %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic checkLevel(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            errorCount++;
            testErrors++;
            $display("Error %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic finishTest(input string name);
        if (testErrors == 0) begin
            testsPassed++;
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: %0d errors", name, testErrors);
        end
        testErrors = 0;
    endtask

    // inputs change a short delay after the edge
    task automatic nextCycle();
        @(posedge clock);
        #2;
    endtask

    task automatic clearInputs();
        keyWrite   = 1'b0;
        keyAddress = '0;
        keyByte    = '0;
        inValid    = 1'b0;
        inByte     = '0;
    endtask

    task automatic applyReset(input int cycles);
        arstN = 1'b0;
        clearInputs();
        repeat (cycles) nextCycle();
        arstN = 1'b1;
        nextCycle();
    endtask

    task automatic loadKeys(input aesBlock key);
        expandKey(key);
        for (int i = 0; i < keyStoreBytes; i++) begin
            keyWrite   = 1'b1;
            keyAddress = keyAddr'(i);
            keyByte    = rkBytes[i];
            nextCycle();
        end
        keyWrite = 1'b0;
        // registered write lands one edge later
        nextCycle();
    endtask

    // in-range key writes and stray bytes
    task automatic driveNoise();
        logic [31:0] r;
        r          = nextRand();
        inValid    = r[0];
        keyWrite   = r[1];
        inByte     = r[15:8];
        keyByte    = r[23:16];
        r          = nextRand();
        keyAddress = keyAddr'(r % keyStoreBytes);
    endtask

    // ends just after the edge that sampled the last outValid
    task automatic runBlock(input aesBlock ct, input bit noise);
        aesBlock expected;
        logic    expOut;
        int      idx;
        expected = modelDecrypt(ct);
        for (int i = 0; i < blockBytes; i++) begin
            inValid = 1'b1;
            inByte  = ct[8*i +: 8];
            nextCycle();
        end
        // rel counts edges after the one taking byte 15
        for (int rel = 0; rel < latency + blockBytes; rel++) begin
            inValid  = 1'b0;
            keyWrite = 1'b0;
            idx      = rel - (latency - 1);
            expOut   = (idx >= 0) && (idx < blockBytes);
            checkLevel("outValid", expOut, outValid);
            checkLevel("busy", expOut || idx < 0, busy);
            if (expOut) checkByte($sformatf("outByte[%0d]", idx), expected[8*idx +: 8], outByte);
            if (noise && busy) driveNoise();
            if (rel < latency + blockBytes - 1) nextCycle();
        end
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        aesBlock key;
        aesBlock ct;
        lcgState = 32'hc723_b6e8;
        arstN    = 1'b0;
        clearInputs();
        buildSboxes();
        applyReset(resetCycles);
        checkLevel("outValid", 1'b0, outValid);
        checkLevel("busy", 1'b0, busy);
        finishTest("powerUpReset");

        // FIPS-197 appendix C.1
        key = fromHex(128'h000102030405060708090a0b0c0d0e0f);
        ct  = fromHex(128'h69c4e0d86a7b0430d8cdb78070b4c55a);
        loadKeys(key);
        if (modelDecrypt(ct) !== fromHex(128'h00112233445566778899aabbccddeeff)) begin
            errorCount++;
            testErrors++;
            $display("reference model does not reproduce the known plaintext");
        end
        runBlock(ct, 1'b0);
        finishTest("knownVector");

        for (int n = 0; n < 20; n++) begin
            loadKeys(randomBlock());
            runBlock(randomBlock(), 1'b0);
        end
        finishTest("randomBlocks");

        // second block starts the cycle after the last outValid
        loadKeys(randomBlock());
        runBlock(randomBlock(), 1'b0);
        runBlock(randomBlock(), 1'b0);
        finishTest("backToBack");

        loadKeys(randomBlock());
        runBlock(randomBlock(), 1'b1);
        runBlock(randomBlock(), 1'b0);
        finishTest("busyLock");

        // block cut off by reset while its bytes are leaving
        ct = randomBlock();
        for (int i = 0; i < blockBytes; i++) begin
            inValid = 1'b1;
            inByte  = ct[8*i +: 8];
            nextCycle();
        end
        inValid = 1'b0;
        repeat (latency + 2) nextCycle();
        checkLevel("outValid", 1'b1, outValid);
        applyReset(4);
        checkLevel("outValid", 1'b0, outValid);
        checkLevel("busy", 1'b0, busy);

        // partial block then reset
        ct = randomBlock();
        for (int i = 0; i < 5; i++) begin
            inValid = 1'b1;
            inByte  = ct[8*i +: 8];
            nextCycle();
        end
        applyReset(4);
        runBlock(randomBlock(), 1'b0);
        finishTest("midRunReset");

        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 testsPassed + testsFailed, testsPassed, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
